// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int word_w = 32;
    localparam int bus_w = 16;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        s_fetch1, s_eval1, s_fetch2, s_eval2, s_store, s_load, s_load2, s_fault
    } state_t;

    typedef enum logic [2:0] {
        am_inh = 3'd0,
        am_imm = 3'd1,
        am_regind = 3'd2,
        am_reg = 3'd3,
        am_pcind = 3'd5
    } addr_mode_t;

    typedef enum logic [7:0] {
        op_nop = 8'h00,
        op_mov = 8'h10, op_cmp = 8'h11, op_neg = 8'h12, op_inc = 8'h13,
        op_dec = 8'h14, op_com = 8'h17,
        op_bra = 8'h20, op_beq = 8'h21, op_bne = 8'h22, op_bgtu = 8'h23,
        op_bgt = 8'h24, op_bge = 8'h25, op_ble = 8'h26, op_blt = 8'h27,
        op_bgeu = 8'h28, op_bltu = 8'h29, op_bleu = 8'h2a, op_brn = 8'h2c,
        op_st = 8'h30, op_ld = 8'h31
    } opcode_t;

    // imm mode reuses the beq/bne codes for the loads
    localparam opcode_t op_lds = op_beq;
    localparam opcode_t op_ldu = op_bne;

    typedef enum logic [3:0] {
        alu_and = 4'd0, alu_or, alu_add, alu_sub, alu_xor, alu_shl, alu_shr, alu_asr
    } alu_op_t;

    typedef struct packed {
        logic carry;
        logic negative;
        logic overflow;
        logic zero;
    } flags_t;

    // alu operand pairing
    typedef enum logic [2:0] {
        src_reg, src_imm, src_one, src_zero, src_ones
    } alu_src_t;

    typedef enum logic [1:0] {
        wr_alu, wr_sext, wr_zext, wr_load
    } wr_src_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::word_w-1:0] a,
    input  logic [cpu_pkg::word_w-1:0] b,
    input  cpu_pkg::alu_op_t           op,
    output logic [cpu_pkg::word_w-1:0] result,
    output cpu_pkg::flags_t            flags_out
);

    localparam int msb = cpu_pkg::word_w - 1;

    logic [cpu_pkg::word_w:0] sum;
    logic [cpu_pkg::word_w:0] diff;

    assign sum = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b}; // top bit is the borrow

    always_comb begin
        flags_out.carry = 1'b0;
        flags_out.overflow = 1'b0;
        case (op)
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or: result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_shl: result = a << b[4:0];
            cpu_pkg::alu_shr: result = a >> b[4:0];
            cpu_pkg::alu_asr: result = $signed(a) >>> b[4:0];
            cpu_pkg::alu_add: begin
                result = sum[msb:0];
                flags_out.carry = sum[cpu_pkg::word_w];
                flags_out.overflow = (a[msb] == b[msb]) && (result[msb] != a[msb]);
            end
            cpu_pkg::alu_sub: begin
                result = diff[msb:0];
                flags_out.carry = diff[cpu_pkg::word_w];
                flags_out.overflow = (a[msb] != b[msb]) && (result[msb] != a[msb]);
            end
            default: result = '0;
        endcase
        flags_out.negative = result[msb];
        flags_out.zero = (result == '0);
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_pkg::reg_addr_t         rd_addr1,
    input  cpu_pkg::reg_addr_t         rd_addr2,
    input  cpu_pkg::reg_addr_t         wr_addr,
    input  logic                       wr_en,
    input  logic [cpu_pkg::word_w-1:0] wr_data,
    output logic [cpu_pkg::word_w-1:0] rd_data1,
    output logic [cpu_pkg::word_w-1:0] rd_data2
);

    logic [cpu_pkg::word_w-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

// File: source/bus_wait_timer.sv
`timescale 1ns/1ps

module bus_wait_timer #(
    parameter int bus_wait = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic data_valid
);

    localparam int cnt_w = $clog2(bus_wait + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (start)
            count <= cnt_w'(bus_wait);
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign data_valid = (count == cnt_w'(1)); // last count

    assert property (@(posedge clk) disable iff (!rst_n) start |-> count == '0)
        else $error("timer restarted while counting");

endmodule

// File: source/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::bus_w-1:0]  data_in,
    input  logic                       ir_load,
    input  logic                       opw_load,
    input  logic                       pc_step,
    input  logic                       pc_branch,
    input  logic                       mar_load,
    input  logic                       mdr_load,
    input  logic                       addr_sel,
    input  logic                       ccr_load,
    input  cpu_pkg::alu_src_t          alu_b_sel,
    input  cpu_pkg::wr_src_t           wr_src,
    input  logic [cpu_pkg::word_w-1:0] alu_result,
    input  cpu_pkg::flags_t            alu_flags,
    input  logic [cpu_pkg::word_w-1:0] rd_data1,
    input  logic [cpu_pkg::word_w-1:0] rd_data2,
    output cpu_pkg::addr_mode_t        ir_mode,
    output cpu_pkg::opcode_t           ir_op,
    output cpu_pkg::reg_addr_t         ir_ra,
    output logic [cpu_pkg::bus_w-1:0]  opw,
    output logic [cpu_pkg::word_w-1:0] alu_a,
    output logic [cpu_pkg::word_w-1:0] alu_b,
    output logic [cpu_pkg::word_w-1:0] wr_data,
    output logic [cpu_pkg::word_w-1:0] addrbus,
    output logic [cpu_pkg::bus_w-1:0]  data_out,
    output cpu_pkg::flags_t            flags
);

    localparam int ext_w = cpu_pkg::word_w - cpu_pkg::bus_w;

    logic [cpu_pkg::word_w-1:0] pc;
    logic [cpu_pkg::word_w-1:0] mar;
    logic [cpu_pkg::word_w-1:0] imm_ext;
    logic [cpu_pkg::bus_w-1:0] ir;
    logic [cpu_pkg::bus_w-1:0] mdr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
            ir <= '0;
            flags <= '0;
        end else begin
            if (pc_branch)
                pc <= pc + imm_ext; // pc already past the offset word
            else if (pc_step)
                pc <= pc + 2;
            if (ir_load)
                ir <= data_in;
            if (ccr_load)
                flags <= alu_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (opw_load)
            opw <= data_in;
        if (mar_load)
            mar <= alu_result;
        if (mdr_load)
            mdr <= rd_data2[cpu_pkg::bus_w-1:0]; // low half of rA
    end

    assign ir_mode = cpu_pkg::addr_mode_t'(ir[15:13]);
    assign ir_op = cpu_pkg::opcode_t'(ir[12:5]);
    assign ir_ra = ir[4:0];

    // regind carries an 11-bit offset, the other modes a full word
    assign imm_ext = (ir_mode == cpu_pkg::am_regind) ?
                     {{(cpu_pkg::word_w - 11){opw[10]}}, opw[10:0]} :
                     {{ext_w{opw[cpu_pkg::bus_w-1]}}, opw};

    assign alu_a = (alu_b_sel == cpu_pkg::src_zero) ? '0 : rd_data1;

    always_comb begin
        case (alu_b_sel)
            cpu_pkg::src_imm: alu_b = imm_ext;
            cpu_pkg::src_one: alu_b = 1;
            cpu_pkg::src_zero: alu_b = rd_data1;
            cpu_pkg::src_ones: alu_b = '1;
            default: alu_b = rd_data2;
        endcase
        case (wr_src)
            cpu_pkg::wr_sext: wr_data = imm_ext;
            cpu_pkg::wr_zext: wr_data = {{ext_w{1'b0}}, opw};
            cpu_pkg::wr_load: wr_data = {{ext_w{1'b0}}, data_in};
            default: wr_data = alu_result;
        endcase
    end

    assign addrbus = addr_sel ? mar : pc;
    assign data_out = mdr;

endmodule

// File: source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_pkg::addr_mode_t       ir_mode,
    input  cpu_pkg::opcode_t          ir_op,
    input  cpu_pkg::reg_addr_t        ir_ra,
    input  logic [cpu_pkg::bus_w-1:0] opw,
    input  cpu_pkg::flags_t           flags,
    input  logic                      data_valid,
    output logic                      timer_start,
    output logic                      ir_load,
    output logic                      opw_load,
    output logic                      pc_step,
    output logic                      pc_branch,
    output logic                      mar_load,
    output logic                      mdr_load,
    output logic                      addr_sel,
    output logic                      ccr_load,
    output logic                      write_out,
    output cpu_pkg::reg_addr_t        rd_addr1,
    output cpu_pkg::reg_addr_t        rd_addr2,
    output cpu_pkg::reg_addr_t        wr_addr,
    output logic                      wr_en,
    output cpu_pkg::wr_src_t          wr_src,
    output cpu_pkg::alu_op_t          alu_op,
    output cpu_pkg::alu_src_t         alu_b_sel
);

    cpu_pkg::state_t state;
    cpu_pkg::state_t state_next;
    logic waiting; // bus read in flight
    logic two_word;

    function automatic logic branch_taken(cpu_pkg::opcode_t op, cpu_pkg::flags_t f);
        logic lt;
        lt = f.negative ^ f.overflow;
        case (op)
            cpu_pkg::op_bra: return 1'b1;
            cpu_pkg::op_beq: return f.zero;
            cpu_pkg::op_bne: return !f.zero;
            cpu_pkg::op_bgtu: return !(f.zero | f.carry);
            cpu_pkg::op_bgt: return !(f.zero | lt);
            cpu_pkg::op_bge: return !lt;
            cpu_pkg::op_ble: return f.zero | lt;
            cpu_pkg::op_blt: return lt;
            cpu_pkg::op_bgeu: return !f.carry;
            cpu_pkg::op_bltu: return f.carry;
            cpu_pkg::op_bleu: return f.carry | f.zero;
            default: return 1'b0; // brn
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::s_fetch1;
            waiting <= 1'b0;
        end else begin
            state <= state_next;
            if (timer_start)
                waiting <= 1'b1;
            else if (data_valid)
                waiting <= 1'b0;
        end
    end

    // legal encodings that carry an operand word; alu codes 8..f excluded
    always_comb begin
        case (ir_mode)
            cpu_pkg::am_reg: two_word = (ir_op[7:3] == 5'h00) ||
                (ir_op inside {cpu_pkg::op_mov, cpu_pkg::op_cmp, cpu_pkg::op_neg,
                               cpu_pkg::op_com});
            cpu_pkg::am_imm: two_word = (ir_op[7:3] == 5'h02) ||
                ir_op == cpu_pkg::op_lds || ir_op == cpu_pkg::op_ldu;
            cpu_pkg::am_pcind: two_word = (ir_op >= cpu_pkg::op_bra &&
                ir_op <= cpu_pkg::op_bleu) || ir_op == cpu_pkg::op_brn;
            cpu_pkg::am_regind: two_word = ir_op == cpu_pkg::op_st || ir_op == cpu_pkg::op_ld;
            default: two_word = 1'b0;
        endcase
    end

    assign addr_sel = state inside {cpu_pkg::s_store, cpu_pkg::s_load, cpu_pkg::s_load2};
    assign write_out = (state == cpu_pkg::s_store);

    always_comb begin
        state_next = state;
        timer_start = 1'b0;
        ir_load = 1'b0;
        opw_load = 1'b0;
        pc_step = 1'b0;
        pc_branch = 1'b0;
        mar_load = 1'b0;
        mdr_load = 1'b0;
        ccr_load = 1'b0;
        rd_addr1 = ir_ra;
        rd_addr2 = opw[4:0];
        wr_addr = ir_ra;
        wr_en = 1'b0;
        wr_src = cpu_pkg::wr_alu;
        alu_op = cpu_pkg::alu_add;
        alu_b_sel = cpu_pkg::src_reg;
        case (state)
            cpu_pkg::s_fetch1: begin
                timer_start = !waiting;
                if (data_valid) begin
                    ir_load = 1'b1;
                    pc_step = 1'b1;
                    state_next = cpu_pkg::s_eval1;
                end
            end
            cpu_pkg::s_eval1: begin
                if (ir_mode == cpu_pkg::am_inh && ir_op == cpu_pkg::op_nop) begin
                    state_next = cpu_pkg::s_fetch1;
                end else if (ir_mode == cpu_pkg::am_reg &&
                             (ir_op == cpu_pkg::op_inc || ir_op == cpu_pkg::op_dec)) begin
                    alu_b_sel = cpu_pkg::src_one;
                    alu_op = (ir_op == cpu_pkg::op_inc) ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
                    wr_en = 1'b1;
                    state_next = cpu_pkg::s_fetch1;
                end else if (two_word) begin
                    timer_start = 1'b1; // this cycle counts toward the second read
                    state_next = cpu_pkg::s_fetch2;
                end else begin
                    state_next = cpu_pkg::s_fault;
                end
            end
            cpu_pkg::s_fetch2: begin
                if (data_valid) begin
                    opw_load = 1'b1;
                    pc_step = 1'b1;
                    state_next = cpu_pkg::s_eval2;
                end
            end
            cpu_pkg::s_eval2: begin
                state_next = cpu_pkg::s_fetch1;
                case (ir_mode)
                    cpu_pkg::am_reg: begin
                        rd_addr1 = opw[12:8];
                        wr_en = 1'b1;
                        if (ir_op[7:4] == 4'h0) begin
                            alu_op = cpu_pkg::alu_op_t'(ir_op[3:0]);
                        end else if (ir_op == cpu_pkg::op_mov) begin
                            alu_b_sel = cpu_pkg::src_zero; // 0 + rB
                        end else if (ir_op == cpu_pkg::op_cmp) begin
                            rd_addr1 = ir_ra;
                            rd_addr2 = opw[12:8];
                            alu_op = cpu_pkg::alu_sub;
                            wr_en = 1'b0;
                            ccr_load = 1'b1;
                        end else if (ir_op == cpu_pkg::op_neg) begin
                            alu_b_sel = cpu_pkg::src_zero;
                            alu_op = cpu_pkg::alu_sub;
                        end else begin
                            alu_b_sel = cpu_pkg::src_ones; // com
                            alu_op = cpu_pkg::alu_xor;
                        end
                    end
                    cpu_pkg::am_imm: begin
                        wr_en = 1'b1;
                        alu_b_sel = cpu_pkg::src_imm;
                        alu_op = cpu_pkg::alu_op_t'(ir_op[3:0]);
                        if (ir_op == cpu_pkg::op_lds)
                            wr_src = cpu_pkg::wr_sext;
                        else if (ir_op == cpu_pkg::op_ldu)
                            wr_src = cpu_pkg::wr_zext;
                    end
                    cpu_pkg::am_pcind: pc_branch = branch_taken(ir_op, flags);
                    cpu_pkg::am_regind: begin
                        rd_addr1 = opw[15:11]; // base rB
                        rd_addr2 = ir_ra;
                        alu_b_sel = cpu_pkg::src_imm;
                        mar_load = 1'b1;
                        mdr_load = (ir_op == cpu_pkg::op_st);
                        state_next = (ir_op == cpu_pkg::op_st) ? cpu_pkg::s_store
                                                                : cpu_pkg::s_load;
                    end
                    default: state_next = cpu_pkg::s_fault;
                endcase
            end
            cpu_pkg::s_store: state_next = cpu_pkg::s_fetch1;
            cpu_pkg::s_load: state_next = cpu_pkg::s_load2;
            cpu_pkg::s_load2: begin
                wr_src = cpu_pkg::wr_load;
                wr_en = 1'b1;
                state_next = cpu_pkg::s_fetch1;
            end
            default: state_next = cpu_pkg::s_fault;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) write_out |=> !write_out)
        else $error("write_out high for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n)
        state == cpu_pkg::s_fault |=> state == cpu_pkg::s_fault)
        else $error("fault state left without reset");

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] reset_pc = 32'h0000_0000,
    parameter int bus_wait = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::bus_w-1:0]  data_in,
    output logic [cpu_pkg::word_w-1:0] addrbus,
    output logic [cpu_pkg::bus_w-1:0]  data_out,
    output logic                       write_out,
    output cpu_pkg::flags_t            ccr
);

    cpu_pkg::addr_mode_t ir_mode;
    cpu_pkg::opcode_t ir_op;
    cpu_pkg::reg_addr_t ir_ra;
    cpu_pkg::reg_addr_t rd_addr1;
    cpu_pkg::reg_addr_t rd_addr2;
    cpu_pkg::reg_addr_t wr_addr;
    cpu_pkg::wr_src_t wr_src;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::alu_src_t alu_b_sel;
    cpu_pkg::flags_t alu_flags;
    logic [cpu_pkg::bus_w-1:0] opw;
    logic [cpu_pkg::word_w-1:0] alu_a;
    logic [cpu_pkg::word_w-1:0] alu_b;
    logic [cpu_pkg::word_w-1:0] alu_result;
    logic [cpu_pkg::word_w-1:0] rd_data1;
    logic [cpu_pkg::word_w-1:0] rd_data2;
    logic [cpu_pkg::word_w-1:0] wr_data;
    logic timer_start;
    logic data_valid;
    logic ir_load;
    logic opw_load;
    logic pc_step;
    logic pc_branch;
    logic mar_load;
    logic mdr_load;
    logic addr_sel;
    logic ccr_load;
    logic wr_en;

    cpu_control u_control (
        .clk, .rst_n, .ir_mode, .ir_op, .ir_ra, .opw, .flags(ccr), .data_valid,
        .timer_start, .ir_load, .opw_load, .pc_step, .pc_branch, .mar_load,
        .mdr_load, .addr_sel, .ccr_load, .write_out, .rd_addr1, .rd_addr2,
        .wr_addr, .wr_en, .wr_src, .alu_op, .alu_b_sel
    );

    bus_wait_timer #(.bus_wait(bus_wait)) u_timer (
        .clk, .rst_n, .start(timer_start), .data_valid
    );

    cpu_datapath #(.reset_pc(reset_pc)) u_datapath (
        .clk, .rst_n, .data_in, .ir_load, .opw_load, .pc_step, .pc_branch,
        .mar_load, .mdr_load, .addr_sel, .ccr_load, .alu_b_sel, .wr_src,
        .alu_result, .alu_flags, .rd_data1, .rd_data2, .ir_mode, .ir_op, .ir_ra,
        .opw, .alu_a, .alu_b, .wr_data, .addrbus, .data_out, .flags(ccr)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .flags_out(alu_flags)
    );

    register_file u_regs (
        .clk, .rst_n, .rd_addr1, .rd_addr2, .wr_addr, .wr_en, .wr_data,
        .rd_data1, .rd_data2
    );

endmodule

// File: testbench/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker #(
    parameter logic [31:0] reset_pc = 32'h0000_0000,
    parameter int mem_words = 4096
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addrbus,
    input  logic [15:0] data_out,
    input  logic        write_out,
    input  logic [3:0]  ccr,
    input  logic [15:0] image [mem_words],
    output logic        done,
    output int          mismatches,
    output int          failures
);

    logic [31:0] regs [32];
    logic [15:0] model_mem [mem_words];
    logic [31:0] exp_addr [$]; // addrbus values in order of change
    logic [3:0] exp_flags [$];
    logic [31:0] st_addr [$];
    logic [15:0] st_data [$];
    int ai;
    int si;
    logic [31:0] last_addr;
    logic last_write;

    function automatic logic [31:0] alu_model(logic [2:0] f, logic [31:0] a, logic [31:0] b);
        case (f)
            3'd0: return a & b;
            3'd1: return a | b;
            3'd2: return a + b;
            3'd3: return a - b;
            3'd4: return a ^ b;
            3'd5: return a << b[4:0];
            3'd6: return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // carry, negative, overflow, zero of a - b
    function automatic logic [3:0] compare_flags(logic [31:0] a, logic [31:0] b);
        logic [31:0] d;
        d = a - b;
        return {a < b, d[31], d[31] != ($signed(a) < $signed(b)), d == 32'h0};
    endfunction

    function automatic logic branch_cond(logic [7:0] op, logic [3:0] f);
        logic c;
        logic n;
        logic v;
        logic z;
        {c, n, v, z} = f;
        case (op)
            8'h20: return 1'b1;
            8'h21: return z;
            8'h22: return !z;
            8'h23: return !c && !z; // unsigned greater
            8'h24: return !z && (n == v);
            8'h25: return n == v;
            8'h26: return z || (n != v);
            8'h27: return n != v;
            8'h28: return !c;
            8'h29: return c;
            8'h2a: return c || z;
            default: return 1'b0;
        endcase
    endfunction

    task automatic expect_addr(input logic [31:0] a, input logic [3:0] f);
        if (exp_addr.size() == 0 || exp_addr[exp_addr.size() - 1] != a) begin
            exp_addr.push_back(a);
            exp_flags.push_back(f);
        end
    endtask

    task automatic undefined_encoding(input logic [31:0] p);
        failures++;
        $display("Model reached an undefined encoding at address %h", p);
    endtask

    task automatic build_model();
        logic [31:0] pc;
        logic [31:0] p;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] w1;
        logic [15:0] w2;
        logic [7:0] op;
        logic [4:0] ra;
        logic [3:0] fl;
        logic stop;
        int steps;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'h0;
        for (int i = 0; i < mem_words; i++)
            model_mem[i] = image[i];
        pc = reset_pc;
        fl = 4'h0;
        stop = 1'b0;
        steps = 0;
        while (!stop) begin
            p = pc;
            w1 = model_mem[p[12:1]];
            op = w1[12:5];
            ra = w1[4:0];
            expect_addr(p, fl);
            pc = p + 2;
            if (w1[15:13] == 3'd0 && op == 8'h00) begin
                pc = p + 2; // nop
            end else if (w1[15:13] == 3'd3 && (op == 8'h13 || op == 8'h14)) begin
                regs[ra] = (op == 8'h13) ? regs[ra] + 1 : regs[ra] - 1;
            end else begin
                w2 = model_mem[pc[12:1]];
                expect_addr(p + 2, fl);
                pc = p + 4;
                expect_addr(pc, fl);
                case (w1[15:13])
                    3'd3: begin
                        b = regs[w2[12:8]];
                        if (op < 8'h08)
                            regs[ra] = alu_model(op[2:0], b, regs[w2[4:0]]);
                        else if (op == 8'h10)
                            regs[ra] = b;
                        else if (op == 8'h11)
                            fl = compare_flags(regs[ra], b);
                        else if (op == 8'h12)
                            regs[ra] = 32'h0 - b;
                        else if (op == 8'h17)
                            regs[ra] = ~b;
                        else
                            stop = 1'b1;
                    end
                    3'd1: begin
                        if (op[7:3] == 5'h02)
                            regs[ra] = alu_model(op[2:0], regs[ra], {{16{w2[15]}}, w2});
                        else if (op == 8'h21)
                            regs[ra] = {{16{w2[15]}}, w2};
                        else if (op == 8'h22)
                            regs[ra] = {16'h0, w2};
                        else
                            stop = 1'b1;
                    end
                    3'd5: begin
                        if (op < 8'h20 || op == 8'h2b || op > 8'h2c) begin
                            stop = 1'b1;
                        end else if (branch_cond(op, fl)) begin
                            a = pc + {{16{w2[15]}}, w2}; // relative to word after offset
                            if (op == 8'h20 && a == p)
                                steps = -1; // final self-branch
                            pc = a;
                            expect_addr(pc, fl);
                        end
                    end
                    3'd2: begin
                        a = regs[w2[15:11]] + {{21{w2[10]}}, w2[10:0]};
                        if (op == 8'h30) begin
                            expect_addr(a, fl);
                            model_mem[a[12:1]] = regs[ra][15:0];
                            st_addr.push_back(a);
                            st_data.push_back(regs[ra][15:0]);
                        end else if (op == 8'h31) begin
                            expect_addr(a, fl);
                            regs[ra] = {16'h0, model_mem[a[12:1]]};
                        end else begin
                            stop = 1'b1;
                        end
                    end
                    default: stop = 1'b1;
                endcase
                if (stop)
                    undefined_encoding(p);
            end
            if (steps < 0) begin
                stop = 1'b1;
            end else begin
                steps++;
                if (steps > 4000) begin
                    failures++;
                    $display("Model never reached a self-branch");
                    stop = 1'b1;
                end
            end
        end
    endtask

    task automatic watch_cycle();
        if (write_out) begin
            if (last_write) begin
                failures++;
                $display("write_out stayed high for two cycles at time %0t", $time);
            end
            if (si >= st_addr.size()) begin
                failures++;
                $display("DUT stored %h to %h at time %0t with no store left in the model",
                         data_out, addrbus, $time);
            end else begin
                if (addrbus !== st_addr[si] || data_out !== st_data[si]) begin
                    mismatches++;
                    $display("Mismatch at time %0t: store %h to %h, expected %h to %h",
                             $time, data_out, addrbus, st_data[si], st_addr[si]);
                end
                si++;
            end
        end
        last_write = write_out;
        if (addrbus !== last_addr) begin
            if (addrbus !== exp_addr[ai]) begin
                mismatches++;
                $display("Mismatch at time %0t: addrbus %h, expected %h",
                         $time, addrbus, exp_addr[ai]);
            end
            if (ccr !== exp_flags[ai]) begin
                mismatches++;
                $display("Mismatch at time %0t: ccr %b at address %h, expected %b",
                         $time, ccr, addrbus, exp_flags[ai]);
            end
            ai++;
            last_addr = addrbus;
        end
        if (ai >= exp_addr.size()) begin
            if (si != st_addr.size()) begin
                failures++;
                $display("%0d stores of the model never reached the bus", st_addr.size() - si);
            end
            done = 1'b1;
        end
    endtask

    initial begin
        done = 1'b0;
        mismatches = 0;
        failures = 0;
        ai = 0;
        si = 0;
        @(posedge rst_n);
        build_model();
        @(negedge clk);
        if (write_out !== 1'b0 || ccr !== 4'h0 || addrbus !== reset_pc) begin
            mismatches++;
            $display("Mismatch at time %0t: after reset addrbus %h write_out %b ccr %b",
                     $time, addrbus, write_out, ccr);
        end
        last_addr = addrbus;
        last_write = write_out;
        ai = 1; // first entry is reset_pc
        while (!done) begin
            @(negedge clk);
            watch_cycle();
        end
    end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam int mem_words = 4096;
    localparam int data_base = 32'h1000;
    localparam int rand_instrs = 46;

    logic clk;
    logic rst_n;
    logic [15:0] data_in;
    logic [31:0] addrbus;
    logic [15:0] data_out;
    logic write_out;
    logic [3:0] ccr;
    logic [15:0] mem [mem_words];
    logic [31:0] rng;
    logic done;
    logic timed_out;
    int mismatches;
    int failures;
    int wp; // next free program word
    int cycles;
    int limit;

    cpu_top #(.reset_pc(reset_pc), .bus_wait(3)) u_cpu_top (
        .clk, .rst_n, .data_in, .addrbus, .data_out, .write_out, .ccr
    );

    cpu_checker #(.reset_pc(reset_pc), .mem_words(mem_words)) u_checker (
        .clk, .rst_n, .addrbus, .data_out, .write_out, .ccr, .image(mem),
        .done, .mismatches, .failures
    );

    assign data_in = mem[addrbus[12:1]];

    always @(posedge clk) begin
        if (write_out)
            mem[addrbus[12:1]] = data_out;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(input int n, output int v);
        rng = xorshift32(rng);
        v = int'(rng % n);
    endtask

    task automatic put_word(input logic [15:0] w);
        mem[wp] = w;
        wp++;
    endtask

    task automatic gen_plain(input int kind);
        int ra;
        int rb;
        int rc;
        int f;
        int v;
        logic [7:0] op;
        draw(16, ra);
        draw(16, rb);
        draw(16, rc);
        draw(8, f);
        draw(65536, v);
        case (kind)
            0, 1: begin // lds, ldu
                put_word({3'd1, (kind == 0) ? 8'h21 : 8'h22, 5'(ra)});
                put_word(16'(v));
            end
            2: begin
                put_word({3'd1, 8'h10 + 8'(f), 5'(ra)});
                put_word(16'(v));
            end
            3: begin
                put_word({3'd3, 8'(f), 5'(ra)});
                put_word({3'b000, 5'(rb), 3'b000, 5'(rc)});
            end
            4: put_word({3'd3, (v % 2 == 0) ? 8'h13 : 8'h14, 5'(ra)});
            5, 6: begin // mov, neg, com or cmp
                op = (kind == 6) ? 8'h11 : (f % 3 == 0) ? 8'h10 : (f % 3 == 1) ? 8'h12 : 8'h17;
                put_word({3'd3, op, 5'(ra)});
                put_word({3'b000, 5'(rb), 8'h00});
            end
            7, 8: begin // st, ld through r31
                put_word({3'd2, (kind == 7) ? 8'h30 : 8'h31, 5'(ra)});
                put_word({5'd31, 11'(2 * (v % 32))});
            end
            default: put_word(16'h0000);
        endcase
    endtask

    task automatic gen_branch();
        int k;
        int c;
        int at;
        draw(3, k);
        draw(12, c);
        put_word({3'd5, (c == 11) ? 8'h2c : 8'h20 + 8'(c), 5'd0});
        at = wp;
        put_word(16'h0000);
        for (int i = 0; i <= k; i++) begin
            draw(10, c);
            gen_plain(c);
        end
        mem[at] = 16'((wp - at - 1) * 2); // skip the words just placed
    endtask

    initial begin
        int kind;
        rst_n = 1'b0;
        rng = 32'h037b5e6e;
        for (int i = 0; i < mem_words; i++)
            mem[i] = 16'(i * 40503) ^ 16'h5a5a;
        wp = reset_pc[12:1];
        put_word({3'd1, 8'h22, 5'd31}); // data base in r31
        put_word(16'(data_base));
        for (int i = 0; i < rand_instrs; i++) begin
            draw(12, kind);
            if (kind >= 10)
                gen_branch();
            else
                gen_plain(kind);
        end
        for (int r = 0; r < 16; r++) begin
            put_word({3'd2, 8'h30, 5'(r)});
            put_word({5'd31, 11'(64 + 2 * r)});
        end
        put_word({3'd5, 8'h20, 5'd0});
        put_word(16'hfffc); // back to itself
        limit = (wp - int'(reset_pc[12:1])) * 5 * 2 + 100;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = !done;
        if (timed_out)
            $display("Timeout: the final self-branch was not reached within %0d cycles", limit);
        $display("Errors: %0d mismatches, %0d other failures", mismatches,
                 failures + int'(timed_out));
        if (timed_out || mismatches != 0 || failures != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// File: build.f
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/bus_wait_timer.sv
source/cpu_datapath.sv
source/cpu_control.sv
source/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_top.sv
